/* list.f */
rtl/fft16_pkg.sv
rtl/radix4_butterfly.sv
rtl/fft_stage_router.sv
rtl/bin_reorder.sv
rtl/fft16_top.sv
verification/tb_clock_gen.sv
verification/fft16_tb.sv

/* rtl/bin_reorder.sv */
module bin_reorder (
    input  logic                                          clk,
    input  logic                                          rst,
    input  logic                                          load,
    input  logic                                          capture,
    input  fft16_pkg::bfly_quad_t [fft16_pkg::N_BFLY-1:0] bfly_results,
    output fft16_pkg::sample_vec_t                        freq_samples,
    output logic                                          done
);

    // Output q of butterfly k in pass 2 is bin k + 4q
    always_ff @(posedge clk) begin
        if (rst) begin
            freq_samples <= '0;
            done         <= 1'b0;
        end else if (capture) begin
            for (int k = 0; k < fft16_pkg::N_BFLY; k++) begin
                for (int q = 0; q < 4; q++) begin
                    freq_samples[k + fft16_pkg::N_BFLY * q] <= bfly_results[k][q];
                end
            end
            done <= 1'b1;
        end else if (load) begin
            done <= 1'b0;  // New transform accepted, bins held until capture
        end
    end

endmodule

/* rtl/fft16_pkg.sv */
package fft16_pkg;

    localparam int SAMPLE_W = 12;  // One real or imaginary part
    localparam int TW_W     = 13;  // One twiddle part
    localparam int TW_FRAC  = 11;  // 2048 is unity
    localparam int N_POINTS = 16;
    localparam int N_BFLY   = 4;   // Radix-4 butterflies per pass

    typedef struct packed {
        logic signed [SAMPLE_W-1:0] re;
        logic signed [SAMPLE_W-1:0] im;
    } cplx_t;

    typedef struct packed {
        logic signed [TW_W-1:0] re;
        logic signed [TW_W-1:0] im;
    } twiddle_t;

    typedef cplx_t [3:0] bfly_quad_t;  // Four legs of one butterfly

    typedef cplx_t [N_POINTS-1:0] sample_vec_t;  // Whole transform

    // W16^k = cos(2*pi*k/16) - j*sin(2*pi*k/16), scaled by 2048 and rounded
    localparam twiddle_t TWIDDLE_ROM [N_POINTS] = '{
        '{re:  13'sd2048, im:  13'sd0   },  // W0
        '{re:  13'sd1892, im: -13'sd784 },  // W1
        '{re:  13'sd1448, im: -13'sd1448},  // W2
        '{re:  13'sd784,  im: -13'sd1892},  // W3
        '{re:  13'sd0,    im: -13'sd2048},  // W4
        '{re: -13'sd784,  im: -13'sd1892},  // W5
        '{re: -13'sd1448, im: -13'sd1448},  // W6
        '{re: -13'sd1892, im: -13'sd784 },  // W7
        '{re: -13'sd2048, im:  13'sd0   },  // W8
        '{re: -13'sd1892, im:  13'sd784 },  // W9
        '{re: -13'sd1448, im:  13'sd1448},  // W10
        '{re: -13'sd784,  im:  13'sd1892},  // W11
        '{re:  13'sd0,    im:  13'sd2048},  // W12
        '{re:  13'sd784,  im:  13'sd1892},  // W13
        '{re:  13'sd1448, im:  13'sd1448},  // W14
        '{re:  13'sd1892, im:  13'sd784 }   // W15
    };

    typedef enum logic [1:0] {
        PASS_IDLE,  // Waiting for start, results held
        PASS_1,     // Butterflies on the input samples
        PASS_2      // Butterflies on the pass-1 results
    } pass_t;

endpackage

/* rtl/fft16_top.sv */
module fft16_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start,
    input  fft16_pkg::sample_vec_t time_samples,
    output fft16_pkg::sample_vec_t freq_samples,
    output logic                   done
);

    fft16_pkg::bfly_quad_t [fft16_pkg::N_BFLY-1:0]      bfly_data;
    fft16_pkg::bfly_quad_t [fft16_pkg::N_BFLY-1:0]      bfly_results;
    fft16_pkg::twiddle_t [fft16_pkg::N_BFLY-1:0][3:0]   bfly_twiddle;
    logic                                               load;
    logic                                               capture;

    fft_stage_router i_router (
        .clk          (clk),
        .rst          (rst),
        .start        (start),
        .time_samples (time_samples),
        .bfly_results (bfly_results),
        .bfly_data    (bfly_data),
        .bfly_twiddle (bfly_twiddle),
        .load         (load),
        .capture      (capture)
    );

    // Butterfly bank reused by both passes
    for (genvar i = 0; i < fft16_pkg::N_BFLY; i++) begin : gen_bfly
        radix4_butterfly i_bfly (
            .data   (bfly_data[i]),
            .w0     (bfly_twiddle[i][0]),
            .w1     (bfly_twiddle[i][1]),
            .w2     (bfly_twiddle[i][2]),
            .w3     (bfly_twiddle[i][3]),
            .result (bfly_results[i])
        );
    end

    bin_reorder i_reorder (
        .clk          (clk),
        .rst          (rst),
        .load         (load),
        .capture      (capture),
        .bfly_results (bfly_results),
        .freq_samples (freq_samples),
        .done         (done)
    );

endmodule

/* rtl/fft_stage_router.sv */
module fft_stage_router (
    input  logic                                       clk,
    input  logic                                       rst,
    input  logic                                       start,
    input  fft16_pkg::sample_vec_t                     time_samples,
    input  fft16_pkg::bfly_quad_t [fft16_pkg::N_BFLY-1:0] bfly_results,
    output fft16_pkg::bfly_quad_t [fft16_pkg::N_BFLY-1:0] bfly_data,
    output fft16_pkg::twiddle_t [fft16_pkg::N_BFLY-1:0][3:0] bfly_twiddle,
    output logic                                       load,
    output logic                                       capture
);

    fft16_pkg::pass_t       pass;
    fft16_pkg::sample_vec_t work;  // Working register shared by both passes

    assign load    = start && (pass == fft16_pkg::PASS_IDLE);  // Start only taken when idle
    assign capture = (pass == fft16_pkg::PASS_2);              // Last-pass results are valid

    // Pass sequencer
    always_ff @(posedge clk) begin
        if (rst) begin
            pass <= fft16_pkg::PASS_IDLE;
        end else begin
            case (pass)
                fft16_pkg::PASS_IDLE: begin
                    if (load) begin
                        pass <= fft16_pkg::PASS_1;
                    end
                end
                fft16_pkg::PASS_1: begin
                    pass <= fft16_pkg::PASS_2;
                end
                fft16_pkg::PASS_2: begin
                    pass <= fft16_pkg::PASS_IDLE;
                end
                default: begin
                    pass <= fft16_pkg::PASS_IDLE;
                end
            endcase
        end
    end

    // Working register, samples on start and pass-1 results afterwards
    always_ff @(posedge clk) begin
        if (load) begin
            work <= time_samples;
        end else if (pass == fft16_pkg::PASS_1) begin
            for (int n = 0; n < fft16_pkg::N_BFLY; n++) begin
                for (int q = 0; q < 4; q++) begin
                    work[fft16_pkg::N_BFLY * n + q] <= bfly_results[n][q];  // Output q of bfly n
                end
            end
        end
    end

    // Data routing
    // Pass 1 wants x[i + 4p] and pass 2 wants output i of bfly p, which was
    // stored at 4p + i. Both passes therefore share one index pattern.
    always_comb begin
        for (int i = 0; i < fft16_pkg::N_BFLY; i++) begin
            for (int p = 0; p < 4; p++) begin
                bfly_data[i][p] = work[i + fft16_pkg::N_BFLY * p];
            end
        end
    end

    // Twiddle selection
    always_comb begin
        for (int i = 0; i < fft16_pkg::N_BFLY; i++) begin
            for (int p = 0; p < 4; p++) begin
                if (pass == fft16_pkg::PASS_2) begin
                    bfly_twiddle[i][p] = fft16_pkg::TWIDDLE_ROM[(p * i) % fft16_pkg::N_POINTS];
                end else begin
                    bfly_twiddle[i][p] = fft16_pkg::TWIDDLE_ROM[0];  // Unity in pass 1
                end
            end
        end
    end

endmodule

/* rtl/radix4_butterfly.sv */
module radix4_butterfly (
    input  fft16_pkg::bfly_quad_t data,
    input  fft16_pkg::twiddle_t   w0,
    input  fft16_pkg::twiddle_t   w1,
    input  fft16_pkg::twiddle_t   w2,
    input  fft16_pkg::twiddle_t   w3,
    output fft16_pkg::bfly_quad_t result
);

    localparam int PROD_W = fft16_pkg::SAMPLE_W + fft16_pkg::TW_W + 1;  // Sum of two products
    localparam int TWD_W  = PROD_W - fft16_pkg::TW_FRAC;                 // After the twiddle shift
    localparam int SUM_W  = TWD_W + 2;                                   // Four-term sum

    fft16_pkg::twiddle_t [3:0] w;

    logic signed [TWD_W-1:0] t_re [4];
    logic signed [TWD_W-1:0] t_im [4];
    logic signed [SUM_W-1:0] s_re [4];
    logic signed [SUM_W-1:0] s_im [4];

    assign w = {w3, w2, w1, w0};

    // Twiddle multiply per leg
    always_comb begin
        logic signed [PROD_W-1:0] p_re;
        logic signed [PROD_W-1:0] p_im;
        for (int p = 0; p < 4; p++) begin
            p_re = data[p].re * w[p].re - data[p].im * w[p].im;
            p_im = data[p].re * w[p].im + data[p].im * w[p].re;
            t_re[p] = p_re[PROD_W-1:fft16_pkg::TW_FRAC];  // Floor shift by TW_FRAC
            t_im[p] = p_im[PROD_W-1:fft16_pkg::TW_FRAC];
        end
    end

    // Radix-4 combinations, -j swaps parts and negates the new imaginary part
    always_comb begin
        s_re[0] = t_re[0] + t_re[1] + t_re[2] + t_re[3];
        s_im[0] = t_im[0] + t_im[1] + t_im[2] + t_im[3];

        s_re[1] = t_re[0] + t_im[1] - t_re[2] - t_im[3];  // 1, -j, -1, +j
        s_im[1] = t_im[0] - t_re[1] - t_im[2] + t_re[3];

        s_re[2] = t_re[0] - t_re[1] + t_re[2] - t_re[3];  // 1, -1, 1, -1
        s_im[2] = t_im[0] - t_im[1] + t_im[2] - t_im[3];

        s_re[3] = t_re[0] - t_im[1] - t_re[2] + t_im[3];  // 1, +j, -1, -j
        s_im[3] = t_im[0] + t_re[1] - t_im[2] - t_re[3];
    end

    // Quarter scaling with floor, back to sample width
    always_comb begin
        for (int q = 0; q < 4; q++) begin
            result[q].re = s_re[q][fft16_pkg::SAMPLE_W+1:2];
            result[q].im = s_im[q][fft16_pkg::SAMPLE_W+1:2];
        end
    end

endmodule

/* run_sim.sh */
#!/bin/sh
# Builds the FFT testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module fft16_tb -f list.f -o fft16_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/fft16_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "Regression passed" "$LOG"; then
    exit 0
fi

echo "Pass line not found in $LOG"
exit 1

/* verification/fft16_tb.sv */
module fft16_tb;

    localparam int CLK_PERIOD = 100;
    localparam int N_TESTS    = 6;
    localparam int N_VECTORS  = 2;
    localparam int N_WORDS    = N_VECTORS * fft16_pkg::N_POINTS * 4;  // Four columns per bin
    localparam int LATENCY    = 2;   // Edges from start to done
    localparam int DONE_LIMIT = 10;  // Give up waiting for done after this

    logic                   clk;
    logic                   rst;
    logic                   start;
    logic                   done;
    fft16_pkg::sample_vec_t time_samples;
    fft16_pkg::sample_vec_t freq_samples;

    logic [fft16_pkg::SAMPLE_W-1:0] file_words [N_WORDS];
    fft16_pkg::sample_vec_t         vec_in  [N_VECTORS];
    fft16_pkg::sample_vec_t         vec_exp [N_VECTORS];

    int seed;
    int test_errors;
    int tests_run;
    int tests_failed;

    tb_clock_gen #(.PERIOD(CLK_PERIOD)) i_clock_gen (.clk(clk));

    fft16_top i_fft16_top (
        .clk          (clk),
        .rst          (rst),
        .start        (start),
        .time_samples (time_samples),
        .freq_samples (freq_samples),
        .done         (done)
    );

    task load_vectors;
        int base;
        $readmemh("verification/fft_input.txt", file_words);
        for (int v = 0; v < N_VECTORS; v++) begin
            for (int b = 0; b < fft16_pkg::N_POINTS; b++) begin
                base = (v * fft16_pkg::N_POINTS + b) * 4;
                vec_in[v][b].re  = file_words[base];
                vec_in[v][b].im  = file_words[base + 1];
                vec_exp[v][b].re = file_words[base + 2];
                vec_exp[v][b].im = file_words[base + 3];
            end
        end
    endtask

    task apply_reset;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
    endtask

    task check_reset_state;
        if (done !== 1'b0) begin
            $display("Fail done: expected 0x0 actual 0x%0h", done);
            test_errors++;
        end
        for (int b = 0; b < fft16_pkg::N_POINTS; b++) begin
            if (freq_samples[b] !== '0) begin
                $display("Fail freq_samples[%0d]: expected 0x%06h actual 0x%06h",
                         b, 24'h0, freq_samples[b]);
                test_errors++;
            end
        end
    endtask

    // Start one transform and count edges until done rises
    task run_transform(input int vec, input bit busy_start);
        int latency;
        @(posedge clk);
        start        <= 1'b1;
        time_samples <= vec_in[vec];
        @(posedge clk);  // Accepting edge
        if (busy_start) begin
            time_samples <= vec_in[(vec + 1) % N_VECTORS];  // Would corrupt bins if taken
        end else begin
            start <= 1'b0;
        end
        latency = 0;
        @(negedge clk);
        while (done !== 1'b1 && latency < DONE_LIMIT) begin
            latency++;
            @(posedge clk);
            start <= 1'b0;
            @(negedge clk);
        end
        if (done !== 1'b1) begin
            $display("done never rose within %0d cycles of the start edge", DONE_LIMIT);
            test_errors++;
        end else if (latency != LATENCY) begin
            $display("Fail done latency: expected 0x%0h actual 0x%0h", LATENCY, latency);
            test_errors++;
        end
    endtask

    task compare_bins(input int vec);
        for (int b = 0; b < fft16_pkg::N_POINTS; b++) begin
            if (freq_samples[b].re !== vec_exp[vec][b].re) begin
                $display("Fail freq_samples[%0d].re: expected 0x%03h actual 0x%03h",
                         b, vec_exp[vec][b].re, freq_samples[b].re);
                test_errors++;
            end
            if (freq_samples[b].im !== vec_exp[vec][b].im) begin
                $display("Fail freq_samples[%0d].im: expected 0x%03h actual 0x%03h",
                         b, vec_exp[vec][b].im, freq_samples[b].im);
                test_errors++;
            end
        end
    endtask

    // Random idle stretch where done and bins hold
    task hold_gap(input int vec);
        int gap;
        gap = $unsigned($random(seed)) % 6;
        for (int c = 0; c <= gap; c++) begin
            if (done !== 1'b1) begin
                $display("Fail done: expected 0x1 actual 0x%0h", done);
                test_errors++;
            end
            compare_bins(vec);
            @(posedge clk);
            @(negedge clk);
        end
    endtask

    task report_test(input string name);
        tests_run++;
        if (test_errors == 0) begin
            $display("Test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("Test %0d %s: %0d errors", tests_run, name, test_errors);
        end
        test_errors = 0;
    endtask

    initial begin
        repeat (N_TESTS * 20 + 10) @(posedge clk);
        $display("Timeout: tests still running after %0d clock cycles", N_TESTS * 20 + 10);
        $display("Regression failed");
        $finish;
    end

    initial begin
        rst          = 1'b1;
        start        = 1'b0;
        time_samples = '0;
        seed         = 32'h29c77320;
        test_errors  = 0;
        tests_run    = 0;
        tests_failed = 0;
        load_vectors();

        apply_reset();
        check_reset_state();
        report_test("reset");

        run_transform(0, 1'b0);
        compare_bins(0);
        report_test("impulse with dc offset");

        hold_gap(0);
        report_test("done and bins held");

        run_transform(1, 1'b0);  // Start while done is still high
        compare_bins(1);
        report_test("back-to-back start");

        hold_gap(1);
        run_transform(0, 1'b1);
        compare_bins(0);
        report_test("start while busy");

        hold_gap(0);
        run_transform(1, 1'b0);
        compare_bins(1);
        hold_gap(1);
        report_test("mixed complex vector");

        $display("Tests run %0d, passed %0d, failed %0d",
                 tests_run, tests_run - tests_failed, tests_failed);
        if (tests_failed == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* verification/fft_input.txt */
// One line per bin, 12-bit two's complement hex
// Columns: input real, input imag, expected real, expected imag
// Vector 1, impulse plus dc offset
1A0 FE0 029 FE0
010 FE0 019 000
010 FE0 019 000
010 FE0 019 000
010 FE0 019 000
010 FE0 019 000
010 FE0 019 000
010 FE0 019 000
010 FE0 019 000
010 FE0 019 000
010 FE0 019 000
010 FE0 019 000
010 FE0 019 000
010 FE0 019 000
010 FE0 019 000
010 FE0 019 000
// Vector 2, mixed complex values
0C8 F88 012 FFA
FAC 034 009 FF8
082 046 00D FFC
FD3 F9D 00B FF8
03C 024 010 FFE
FEC FF8 00F FF1
00E FE2 FFF FFC
021 005 010 00B
000 000 020 000
000 000 022 FED
000 000 010 FE1
000 000 002 FE9
000 000 FFE FF2
000 000 000 FFB
000 000 005 FFE
000 000 00B 002

/* verification/tb_clock_gen.sv */
module tb_clock_gen #(
    parameter int PERIOD = 100
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2) clk = ~clk;  // Half period per phase
        end
    end

endmodule
